// ==== hdl/stq_pkg.sv ====
/* store queue shared definitions
   word geometry, entry payload types and the load check result code */
package stq_pkg;

  localparam int BYTES  = 8;         // bytes per store word
  localparam int DATA_W = 8 * BYTES; // one 64 bit word

  // byte-enable mask, bit n selects data[8n+7:8n]
  typedef logic [BYTES-1:0] bytes_t;

  typedef logic [DATA_W-1:0] data_t;

  // outcome of checking one load against the queued stores
  typedef enum logic [1:0] {
    LD_MISS  = 2'd0, // no older store touches the load bytes
    LD_FWD   = 2'd1, // youngest overlapping store covers every load byte
    LD_CONFL = 2'd2  // youngest overlapping store covers only part of them
  } ld_result_e;

endpackage

// ==== hdl/stq_view_if.sv ====
/* store queue contents view
   entry state from the ring to the address matcher, byte checker and selector */
interface stq_view_if #(
  parameter int DEPTH  = 16,
  parameter int ADDR_W = 29
);
  import stq_pkg::*;

  logic [DEPTH-1:0]         valid;
  logic [ADDR_W-1:0]        addr [DEPTH];
  bytes_t                   bytes [DEPTH];
  data_t                    data [DEPTH];
  logic [$clog2(DEPTH)-1:0] head; // oldest entry

  modport ring   (output valid, output addr, output bytes, output data, output head);
  modport match  (input valid, input addr);
  modport bcover (input bytes);
  modport select (input head, input data);

endinterface

// ==== hdl/stq_ring.sv ====
/* store queue entry ring
   allocates stores at the tail, drains the head into the write-back register
   on retire and empties on flush */
module stq_ring #(
  parameter int DEPTH  = 16,
  parameter int ADDR_W = 29
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              st_en,
  input  logic [ADDR_W-1:0] st_addr,
  input  stq_pkg::bytes_t   st_bytes,
  input  stq_pkg::data_t    st_data,
  output logic              st_ready,
  input  logic              ret_en,
  input  logic              flush,
  output logic              wb_valid,
  output logic [ADDR_W-1:0] wb_addr,
  output stq_pkg::bytes_t   wb_bytes,
  output stq_pkg::data_t    wb_data,
  stq_view_if.ring          view
);
  import stq_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  // pointers carry one extra wrap bit to tell full from empty
  logic [IDX_W:0]    head_q;
  logic [IDX_W:0]    tail_q;
  logic [IDX_W-1:0]  head_idx;
  logic [IDX_W-1:0]  tail_idx;
  logic [DEPTH-1:0]  valid_q;
  logic [ADDR_W-1:0] addr_q [DEPTH];
  bytes_t            bytes_q [DEPTH];
  data_t             data_q [DEPTH];
  logic              empty;
  logic              full;
  logic              do_st;
  logic              do_ret;

  if ((1 << IDX_W) != DEPTH) begin : g_depth_chk
    $error("stq_ring DEPTH must be a power of two");
  end

  assign head_idx = head_q[IDX_W-1:0];
  assign tail_idx = tail_q[IDX_W-1:0];
  assign empty    = (head_q == tail_q);
  assign full     = (head_idx == tail_idx) && (head_q[IDX_W] != tail_q[IDX_W]);
  assign st_ready = !full;

  // flush wins over both allocation and retire
  assign do_st  = st_en && !full && !flush;
  assign do_ret = ret_en && !empty && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q   <= '0;
      tail_q   <= '0;
      valid_q  <= '0;
      wb_valid <= 1'b0;
    end else if (flush) begin
      head_q   <= '0;
      tail_q   <= '0;
      valid_q  <= '0;
      wb_valid <= 1'b0; // flushed stores never reach memory
    end else begin
      wb_valid <= do_ret;
      if (do_st) begin
        valid_q[tail_idx] <= 1'b1;
        tail_q            <= tail_q + 1'b1;
      end
      if (do_ret) begin
        valid_q[head_idx] <= 1'b0; // head and tail differ here, queue not empty
        head_q            <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_st) begin
      addr_q[tail_idx]  <= st_addr;
      bytes_q[tail_idx] <= st_bytes;
      data_q[tail_idx]  <= st_data;
    end
    if (do_ret) begin
      wb_addr  <= addr_q[head_idx];
      wb_bytes <= bytes_q[head_idx];
      wb_data  <= data_q[head_idx];
    end
  end

  assign view.valid = valid_q;
  assign view.addr  = addr_q;
  assign view.bytes = bytes_q;
  assign view.data  = data_q;
  assign view.head  = head_idx;

  // producer must hold stores back while st_ready is low
  a_no_st_when_full : assert property (
    @(posedge clk) disable iff (rst) full |-> !st_en
  ) else $error("store presented while queue full");

  a_no_ret_when_empty : assert property (
    @(posedge clk) disable iff (rst) empty |-> !ret_en
  ) else $error("retire requested while queue empty");

endmodule

// ==== hdl/stq_addr_match.sv ====
/* store queue address match
   compares the load word address against every valid entry at once */
module stq_addr_match #(
  parameter int DEPTH  = 16,
  parameter int ADDR_W = 29
) (
  input  logic [ADDR_W-1:0] ld_addr,
  output logic [DEPTH-1:0]  addr_hit,
  stq_view_if.match         view
);

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      addr_hit[i] = view.valid[i] && (view.addr[i] == ld_addr);
    end
  end

endmodule

// ==== hdl/stq_byte_cover.sv ====
/* store queue byte check
   per entry, whether the store mask shares any load byte and whether it
   holds all of them */
module stq_byte_cover #(
  parameter int DEPTH = 16
) (
  input  stq_pkg::bytes_t  ld_bytes,
  output logic [DEPTH-1:0] overlap,
  output logic [DEPTH-1:0] covered,
  stq_view_if.bcover       view
);

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      overlap[i] = |(view.bytes[i] & ld_bytes);
      // no load byte may fall outside the store mask
      covered[i] = ~|(ld_bytes & ~view.bytes[i]);
    end
  end

endmodule

// ==== hdl/stq_fwd_select.sv ====
/* store queue forward select
   picks the youngest overlapping store and registers the load result and
   forwarded data one cycle after the load */
module stq_fwd_select #(
  parameter int DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ld_en,
  input  stq_pkg::bytes_t      ld_bytes,
  input  logic [DEPTH-1:0]     addr_hit,
  input  logic [DEPTH-1:0]     overlap,
  input  logic [DEPTH-1:0]     covered,
  stq_view_if.select           view,
  output logic                 ld_valid,
  output stq_pkg::ld_result_e  ld_result,
  output stq_pkg::data_t       ld_data
);
  import stq_pkg::*;

  logic [DEPTH-1:0]   cand;
  logic [2*DEPTH-1:0] cand_rot_w;
  logic [DEPTH-1:0]   cand_rot;  // bit 0 is the oldest entry
  logic [DEPTH-1:0]   pick_rot;
  logic [2*DEPTH-1:0] pick_w;
  logic [DEPTH-1:0]   pick;      // one-hot in entry order
  logic               found;
  logic               pick_cover;
  data_t              byte_mask;
  data_t              fwd_data;
  ld_result_e         next_result;
  data_t              next_data;

  assign cand = addr_hit & overlap;

  // rotate by head so age order becomes index order
  assign cand_rot_w = {cand, cand} >> view.head;
  assign cand_rot   = cand_rot_w[DEPTH-1:0];

  // keep the highest set bit, closest to the tail
  always_comb begin
    for (int k = 0; k < DEPTH; k++) begin
      pick_rot[k] = ((cand_rot >> k) == DEPTH'(1)); // set here, nothing younger above
    end
  end

  assign pick_w     = {pick_rot, pick_rot} << view.head;
  assign pick       = pick_w[2*DEPTH-1:DEPTH];
  assign found      = |pick;
  assign pick_cover = |(pick & covered);

  always_comb begin
    for (int b = 0; b < BYTES; b++) begin
      byte_mask[8*b +: 8] = {8{ld_bytes[b]}};
    end
  end

  // pick is one-hot so or-ing the selected words acts as a mux
  always_comb begin
    fwd_data = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (pick[i]) begin
        fwd_data = fwd_data | view.data[i];
      end
    end
  end

  always_comb begin
    next_result = LD_MISS;
    next_data   = '0;
    if (found && pick_cover) begin
      next_result = LD_FWD;
      next_data   = fwd_data & byte_mask; // bytes the load did not ask for read as zero
    end else if (found) begin
      next_result = LD_CONFL;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_valid <= 1'b0;
    end else begin
      ld_valid <= ld_en;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_en) begin
      ld_result <= next_result;
      ld_data   <= next_data;
    end
  end

  a_pick_onehot : assert property (
    @(posedge clk) disable iff (rst) ld_en |-> $onehot0(pick)
  ) else $error("forward select picked more than one entry");

endmodule

// ==== hdl/stq_top.sv ====
/* store queue top
   ring storage, load address and byte checks and youngest-store select */
module stq_top #(
  parameter int DEPTH  = 16,
  parameter int ADDR_W = 29
) (
  input  logic                clk,
  input  logic                rst,
  // store allocation
  input  logic                st_en,
  input  logic [ADDR_W-1:0]   st_addr,
  input  stq_pkg::bytes_t     st_bytes,
  input  stq_pkg::data_t      st_data,
  output logic                st_ready,
  // retire and flush
  input  logic                ret_en,
  input  logic                flush,
  // write-back of retired stores
  output logic                wb_valid,
  output logic [ADDR_W-1:0]   wb_addr,
  output stq_pkg::bytes_t     wb_bytes,
  output stq_pkg::data_t      wb_data,
  // load check
  input  logic                ld_en,
  input  logic [ADDR_W-1:0]   ld_addr,
  input  stq_pkg::bytes_t     ld_bytes,
  output logic                ld_valid,
  output stq_pkg::ld_result_e ld_result,
  output stq_pkg::data_t      ld_data
);

  logic [DEPTH-1:0] addr_hit;
  logic [DEPTH-1:0] overlap;
  logic [DEPTH-1:0] covered;

  stq_view_if #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) view_i ();

  stq_ring #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) ring_i (
    .clk      (clk),
    .rst      (rst),
    .st_en    (st_en),
    .st_addr  (st_addr),
    .st_bytes (st_bytes),
    .st_data  (st_data),
    .st_ready (st_ready),
    .ret_en   (ret_en),
    .flush    (flush),
    .wb_valid (wb_valid),
    .wb_addr  (wb_addr),
    .wb_bytes (wb_bytes),
    .wb_data  (wb_data),
    .view     (view_i.ring)
  );

  stq_addr_match #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) addr_match_i (
    .ld_addr  (ld_addr),
    .addr_hit (addr_hit),
    .view     (view_i.match)
  );

  stq_byte_cover #(.DEPTH(DEPTH)) byte_cover_i (
    .ld_bytes (ld_bytes),
    .overlap  (overlap),
    .covered  (covered),
    .view     (view_i.bcover)
  );

  stq_fwd_select #(.DEPTH(DEPTH)) fwd_select_i (
    .clk       (clk),
    .rst       (rst),
    .ld_en     (ld_en),
    .ld_bytes  (ld_bytes),
    .addr_hit  (addr_hit),
    .overlap   (overlap),
    .covered   (covered),
    .view      (view_i.select),
    .ld_valid  (ld_valid),
    .ld_result (ld_result),
    .ld_data   (ld_data)
  );

endmodule

// ==== test/stq_checker.sv ====
/* store queue checker
   compares load results, write-backs and st_ready with the expected values */
module stq_checker #(
  parameter int ADDR_W = 29
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                chk_active,
  input  logic                chk_ld,
  input  logic                chk_wb,
  input  stq_pkg::ld_result_e exp_result,
  input  stq_pkg::data_t      exp_ld_data,
  input  logic [ADDR_W-1:0]   exp_wb_addr,
  input  stq_pkg::bytes_t     exp_wb_bytes,
  input  stq_pkg::data_t      exp_wb_data,
  input  logic                exp_ready,
  input  logic                st_ready,
  input  logic                wb_valid,
  input  logic [ADDR_W-1:0]   wb_addr,
  input  stq_pkg::bytes_t     wb_bytes,
  input  stq_pkg::data_t      wb_data,
  input  logic                ld_valid,
  input  stq_pkg::ld_result_e ld_result,
  input  stq_pkg::data_t      ld_data,
  output int                  ld_errs,
  output int                  wb_errs,
  output int                  ready_errs
);
  timeunit 1ns;
  timeprecision 100ps;
  import stq_pkg::*;

  logic              ld_due;   // a load was sampled at the last edge
  logic              wb_due;
  ld_result_e        want_result;
  data_t             want_ld_data;
  logic [ADDR_W-1:0] want_wb_addr;
  bytes_t            want_wb_bytes;
  data_t             want_wb_data;

  always @(posedge clk) begin
    if (rst) begin
      ld_due <= 1'b0;
      wb_due <= 1'b0;
    end else begin
      ld_due        <= chk_active && chk_ld;
      wb_due        <= chk_active && chk_wb;
      want_result   <= exp_result;
      want_ld_data  <= exp_ld_data;
      want_wb_addr  <= exp_wb_addr;
      want_wb_bytes <= exp_wb_bytes;
      want_wb_data  <= exp_wb_data;
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst) begin
      ld_errs    = 0;
      wb_errs    = 0;
      ready_errs = 0;
    end else begin
      if (chk_active && st_ready !== exp_ready) begin
        $display("ERR %0t st_ready exp %0b act %0b", $time, exp_ready, st_ready);
        ready_errs++;
      end
      if (ld_due) begin
        if (ld_valid !== 1'b1) begin
          $display("load result missing at %0t, ld_valid stayed low", $time);
          ld_errs++;
        end else begin
          if (ld_result !== want_result) begin
            $display("ERR %0t ld_result exp %s act %s", $time, want_result.name(),
                     ld_result.name());
            ld_errs++;
          end
          if (ld_data !== want_ld_data) begin
            $display("ERR %0t ld_data exp %h act %h", $time, want_ld_data, ld_data);
            ld_errs++;
          end
        end
      end else if (ld_valid !== 1'b0) begin
        $display("ld_valid high at %0t with no load in the cycle before", $time);
        ld_errs++;
      end
      if (wb_due) begin
        if (wb_valid !== 1'b1) begin
          $display("write-back missing at %0t, wb_valid stayed low", $time);
          wb_errs++;
        end else begin
          if (wb_addr !== want_wb_addr) begin
            $display("ERR %0t wb_addr exp %h act %h", $time, want_wb_addr, wb_addr);
            wb_errs++;
          end
          if (wb_bytes !== want_wb_bytes) begin
            $display("ERR %0t wb_bytes exp %h act %h", $time, want_wb_bytes, wb_bytes);
            wb_errs++;
          end
          if (wb_data !== want_wb_data) begin
            $display("ERR %0t wb_data exp %h act %h", $time, want_wb_data, wb_data);
            wb_errs++;
          end
        end
      end else if (wb_valid !== 1'b0) begin
        $display("wb_valid high at %0t with no retire in the cycle before", $time);
        wb_errs++;
      end
    end
  end

endmodule

// ==== test/stq_tb.sv ====
/* store queue testbench
   applies a table of store, load, retire and flush rows, one per clock */
module stq_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import stq_pkg::*;

  localparam int DEPTH  = 16;
  localparam int ADDR_W = 29;

  typedef enum logic [2:0] {OP_IDLE, OP_ST, OP_LD, OP_RET, OP_FLUSH} op_e;

  // addr, bytes and data are stimulus for stores and loads,
  // and the expected write-back for retires
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    bytes_t            bytes;
    data_t             data;
    ld_result_e        result;
    data_t             ld_data;
    logic              ready;   // st_ready while the row is on the inputs
  } row_t;

  row_t rows [$];
  logic table_ready = 1'b0;
  int   total;

  logic              clk;
  logic              rst;
  logic              st_en;
  logic [ADDR_W-1:0] st_addr;
  bytes_t            st_bytes;
  data_t             st_data;
  logic              st_ready;
  logic              ret_en;
  logic              flush;
  logic              wb_valid;
  logic [ADDR_W-1:0] wb_addr;
  bytes_t            wb_bytes;
  data_t             wb_data;
  logic              ld_en;
  logic [ADDR_W-1:0] ld_addr;
  bytes_t            ld_bytes;
  logic              ld_valid;
  ld_result_e        ld_result;
  data_t             ld_data;

  logic              chk_active;
  logic              chk_ld;
  logic              chk_wb;
  row_t              cur;
  int                ld_errs;
  int                wb_errs;
  int                ready_errs;

  always #50 clk = ~clk;

  stq_top #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) stq_top_i (
    .clk(clk), .rst(rst),
    .st_en(st_en), .st_addr(st_addr), .st_bytes(st_bytes), .st_data(st_data),
    .st_ready(st_ready), .ret_en(ret_en), .flush(flush),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_bytes(wb_bytes), .wb_data(wb_data),
    .ld_en(ld_en), .ld_addr(ld_addr), .ld_bytes(ld_bytes),
    .ld_valid(ld_valid), .ld_result(ld_result), .ld_data(ld_data)
  );

  stq_checker #(.ADDR_W(ADDR_W)) chk_i (
    .clk(clk), .rst(rst), .chk_active(chk_active), .chk_ld(chk_ld), .chk_wb(chk_wb),
    .exp_result(cur.result), .exp_ld_data(cur.ld_data), .exp_wb_addr(cur.addr),
    .exp_wb_bytes(cur.bytes), .exp_wb_data(cur.data), .exp_ready(cur.ready),
    .st_ready(st_ready), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_bytes(wb_bytes),
    .wb_data(wb_data), .ld_valid(ld_valid), .ld_result(ld_result), .ld_data(ld_data),
    .ld_errs(ld_errs), .wb_errs(wb_errs), .ready_errs(ready_errs)
  );

  function automatic void add_row(input op_e op, input logic [ADDR_W-1:0] addr,
                                  input bytes_t bytes, input data_t data,
                                  input ld_result_e result, input data_t ld_data,
                                  input logic ready);
    row_t r;
    r.op      = op;
    r.addr    = addr;
    r.bytes   = bytes;
    r.data    = data;
    r.result  = result;
    r.ld_data = ld_data;
    r.ready   = ready;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    add_row(OP_ST,  29'h1000, 8'hff, 64'h0123_4567_89ab_cdef, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h1000, 8'h0f, '0, LD_FWD, 64'h0000_0000_89ab_cdef, 1'b1);
    add_row(OP_LD,  29'h1000, 8'hf0, '0, LD_FWD, 64'h0123_4567_0000_0000, 1'b1);
    add_row(OP_ST,  29'h2000, 8'h0f, 64'hdead_beef_cafe_f00d, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h2000, 8'h3c, '0, LD_CONFL, '0, 1'b1); // half inside the store
    add_row(OP_LD,  29'h3000, 8'hff, '0, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h2000, 8'hf0, '0, LD_MISS, '0, 1'b1);  // disjoint bytes
    add_row(OP_ST,  29'h1000, 8'hff, 64'hfedc_ba98_7654_3210, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h1000, 8'hff, '0, LD_FWD, 64'hfedc_ba98_7654_3210, 1'b1);
    add_row(OP_ST,  29'h3000, 8'h0f, 64'h5555_6666_7777_8888, LD_MISS, '0, 1'b1);
    add_row(OP_ST,  29'h3000, 8'hf0, 64'h9999_aaaa_bbbb_cccc, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h3000, 8'hff, '0, LD_CONFL, '0, 1'b1);
    add_row(OP_LD,  29'h3000, 8'h0f, '0, LD_FWD, 64'h0000_0000_7777_8888, 1'b1);
    // drain in allocation order
    add_row(OP_RET, 29'h1000, 8'hff, 64'h0123_4567_89ab_cdef, LD_MISS, '0, 1'b1);
    add_row(OP_RET, 29'h2000, 8'h0f, 64'hdead_beef_cafe_f00d, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h2000, 8'h0f, '0, LD_MISS, '0, 1'b1);
    add_row(OP_RET, 29'h1000, 8'hff, 64'hfedc_ba98_7654_3210, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h1000, 8'hff, '0, LD_MISS, '0, 1'b1);
    // fill up past the wrap, store 13 reuses the address of store 0
    for (int k = 0; k < DEPTH - 2; k++) begin
      add_row(OP_ST, 29'h100 + 29'(k % 13), 8'hff, 64'h5a5a_0000_0000_0000 | 64'(k),
              LD_MISS, '0, 1'b1);
    end
    add_row(OP_IDLE, '0, '0, '0, LD_MISS, '0, 1'b0);
    add_row(OP_LD,  29'h100, 8'hff, '0, LD_FWD, 64'h5a5a_0000_0000_000d, 1'b0);
    add_row(OP_LD,  29'h10c, 8'h01, '0, LD_FWD, 64'h0000_0000_0000_000c, 1'b0);
    add_row(OP_LD,  29'h3000, 8'hff, '0, LD_CONFL, '0, 1'b0);
    add_row(OP_FLUSH, '0, '0, '0, LD_MISS, '0, 1'b0);
    add_row(OP_IDLE, '0, '0, '0, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h3000, 8'hff, '0, LD_MISS, '0, 1'b1);
    add_row(OP_LD,  29'h100, 8'hff, '0, LD_MISS, '0, 1'b1);
  endfunction

  task automatic drive_row(input row_t r, input logic active);
    cur        = r;
    st_en      = active && (r.op == OP_ST);
    ret_en     = active && (r.op == OP_RET);
    flush      = active && (r.op == OP_FLUSH);
    ld_en      = active && (r.op == OP_LD);
    st_addr    = r.addr;
    st_bytes   = r.bytes;
    st_data    = r.data;
    ld_addr    = r.addr;
    ld_bytes   = r.bytes;
    chk_active = active;
    chk_ld     = active && (r.op == OP_LD);
    chk_wb     = active && (r.op == OP_RET);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    drive_row('0, 1'b0);
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (rows[i]) begin
      drive_row(rows[i], 1'b1);
      @(posedge clk);
      #1;
    end
    drive_row('0, 1'b0);
    repeat (2) @(posedge clk); // last result is checked on the way
    total = ld_errs + wb_errs + ready_errs;
    $display("errors: load %0d, write-back %0d, st_ready %0d, total %0d",
             ld_errs, wb_errs, ready_errs, total);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready);
    #((rows.size() + 10) * 200);
    $display("timeout: the %0d table rows did not finish in time", rows.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/stq_pkg.sv
hdl/stq_view_if.sv
hdl/stq_ring.sv
hdl/stq_addr_match.sv
hdl/stq_byte_cover.sv
hdl/stq_fwd_select.sv
hdl/stq_top.sv
test/stq_checker.sv
test/stq_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module stq_tb -f files.f -o stq_sim

./obj_dir/stq_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
